//--- run.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module rv_core_tb \
    -f rv_core.f \
    --Mdir obj_dir -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation passed"

//--- rv_core.f
src/rv_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/int_alu.sv
src/branch_unit.sv
src/retire_unit.sv
src/rv_core.sv
tests/rv_core_tb.sv

//--- src/branch_unit.sv
/* branch and jump resolution */
module branch_unit (
    input  rv_pkg::inst_fmt_t       fmt,
    input  rv_pkg::opcode_t         opcode,
    input  logic [2:0]              funct3,
    input  logic [rv_pkg::xlen-1:0] rdata1,
    input  logic [rv_pkg::xlen-1:0] rdata2,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] pc,
    output logic                    taken,
    output logic [rv_pkg::xlen-1:0] target
);
    import rv_pkg::*;

    logic [xlen-1:0] jalr_sum;
    logic            cond_met;

    assign jalr_sum = rdata1 + imm;

    // jalr is register relative with bit 0 cleared, the rest pc relative
    assign target = (opcode == jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;

    always_comb begin
        unique case (branch_cond_t'(funct3))
            beq:     cond_met = (rdata1 == rdata2);
            bne:     cond_met = (rdata1 != rdata2);
            blt:     cond_met = $signed(rdata1) < $signed(rdata2);
            bge:     cond_met = $signed(rdata1) >= $signed(rdata2);
            bltu:    cond_met = rdata1 < rdata2;
            bgeu:    cond_met = rdata1 >= rdata2;
            default: cond_met = 1'b0;  // funct3 010 / 011 never branch
        endcase
    end

    always_comb begin
        if (opcode == jal || opcode == jalr) begin
            taken = 1'b1;
        end else if (fmt == fmt_b) begin
            taken = cond_met;
        end else begin
            taken = 1'b0;
        end
    end

endmodule

//--- src/instr_decoder.sv
/* RV32I instruction decoder */
module instr_decoder (
    input  logic [rv_pkg::xlen-1:0]      inst,
    output logic [rv_pkg::reg_idx_w-1:0] rd,
    output logic [rv_pkg::reg_idx_w-1:0] rs1,
    output logic [rv_pkg::reg_idx_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]      imm,
    output rv_pkg::inst_fmt_t            fmt,
    output rv_pkg::opcode_t              opcode,
    output logic [2:0]                   funct3,
    output rv_pkg::alu_op_t              alu_op,
    output rv_pkg::wb_sel_t              wb_sel,
    output logic                         illegal
);
    import rv_pkg::*;

    logic [6:0] funct7;

    assign opcode = opcode_t'(inst[6:0]);
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    // format, write-back source and illegal flag from the opcode
    always_comb begin
        illegal = 1'b0;
        unique case (opcode)
            op: begin
                fmt    = fmt_r;
                wb_sel = wb_alu;
            end
            op_imm, jalr: begin
                fmt    = fmt_i;
                wb_sel = (opcode == jalr) ? wb_link : wb_alu;
            end
            lui, auipc: begin
                fmt    = fmt_u;
                wb_sel = wb_alu;
            end
            jal: begin
                fmt    = fmt_j;
                wb_sel = wb_link;
            end
            branch: begin
                fmt    = fmt_b;
                wb_sel = wb_none;  // branches never write rd
            end
            default: begin  // loads, stores, system and the rest
                fmt     = fmt_n;
                wb_sel  = wb_none;
                illegal = 1'b1;
            end
        endcase
    end

    // sign-extended immediates
    always_comb begin
        unique case (fmt)
            fmt_i:   imm = {{20{inst[31]}}, inst[31:20]};
            fmt_b:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {inst[31:12], 12'b0};
            fmt_j:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;  // R and unknown formats carry none
        endcase
    end

    always_comb begin
        alu_op = alu_add;  // address and link arithmetic
        if (opcode == op || opcode == op_imm) begin
            unique case (funct3)
                3'b000:  alu_op = (opcode == op && funct7[5]) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;  // srai sets inst[30] too
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

endmodule

//--- src/int_alu.sv
/* integer ALU */
module int_alu (
    input  rv_pkg::inst_fmt_t       fmt,
    input  rv_pkg::opcode_t         opcode,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic [rv_pkg::xlen-1:0] rdata1,
    input  logic [rv_pkg::xlen-1:0] rdata2,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] alu_result
);
    import rv_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      shamt;

    // operand A
    always_comb begin
        if (fmt == fmt_u) begin
            a = (opcode == lui) ? '0 : pc;  // lui is 0 + imm, auipc is pc + imm
        end else begin
            a = rdata1;
        end
    end

    assign b     = (fmt == fmt_r) ? rdata2 : imm;
    assign shamt = b[4:0];

    always_comb begin
        unique case (alu_op)
            alu_add:  alu_result = a + b;
            alu_sub:  alu_result = a - b;
            alu_sll:  alu_result = a << shamt;
            alu_slt:  alu_result = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: alu_result = {{(xlen - 1){1'b0}}, a < b};
            alu_xor:  alu_result = a ^ b;
            alu_srl:  alu_result = a >> shamt;
            alu_sra:  alu_result = $signed(a) >>> shamt;  // keeps the sign bit
            alu_or:   alu_result = a | b;
            alu_and:  alu_result = a & b;
            default:  alu_result = '0;
        endcase
    end

endmodule

//--- src/reg_file.sv
/* integer register file */
module reg_file (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [rv_pkg::reg_idx_w-1:0] raddr1,
    input  logic [rv_pkg::reg_idx_w-1:0] raddr2,
    output logic [rv_pkg::xlen-1:0]      rdata1,
    output logic [rv_pkg::xlen-1:0]      rdata2,
    input  logic                         wen,
    input  logic [rv_pkg::reg_idx_w-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]      wdata
);
    import rv_pkg::*;

    localparam int num_regs = 1 << reg_idx_w;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin  // x0 writes dropped here
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero whatever the array holds
    always_comb begin
        rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    end

endmodule

//--- src/retire_unit.sv
/* PC, write-back and retire record */
module retire_unit #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inst_valid,
    input  logic [rv_pkg::reg_idx_w-1:0] rd,
    input  rv_pkg::wb_sel_t              wb_sel,
    input  logic                         illegal,
    input  logic [rv_pkg::xlen-1:0]      alu_result,
    input  logic                         taken,
    input  logic [rv_pkg::xlen-1:0]      target,
    output logic [rv_pkg::xlen-1:0]      pc,
    output logic                         wen,
    output logic [rv_pkg::reg_idx_w-1:0] waddr,
    output logic [rv_pkg::xlen-1:0]      wdata,
    output logic                         retire_valid,
    output logic [rv_pkg::xlen-1:0]      retire_pc,
    output logic [rv_pkg::reg_idx_w-1:0] retire_rd,
    output logic                         retire_we,
    output logic [rv_pkg::xlen-1:0]      retire_wdata,
    output logic [rv_pkg::xlen-1:0]      retire_next_pc,
    output logic                         retire_illegal
);
    import rv_pkg::*;

    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] next_pc;

    assign seq_pc  = pc + xlen'(4);
    assign next_pc = taken ? target : seq_pc;  // illegal ops are never taken

    // write port of the register file, lands on the same edge as retire
    assign wen   = inst_valid && (wb_sel != wb_none);
    assign waddr = rd;
    assign wdata = (wb_sel == wb_link) ? seq_pc : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc             <= reset_pc;
            retire_valid   <= 1'b0;
            retire_we      <= 1'b0;
            retire_illegal <= 1'b0;
        end else begin
            retire_valid <= inst_valid;
            retire_we    <= wen;  // low in idle cycles
            if (inst_valid) begin
                pc             <= next_pc;
                retire_illegal <= illegal;
            end
        end
    end

    // retire payload, only meaningful with retire_valid
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire_pc      <= pc;
            retire_rd      <= rd;
            retire_wdata   <= wdata;
            retire_next_pc <= next_pc;
        end
    end

endmodule

//--- src/rv_core.sv
/* RV32I single-cycle core */
module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inst_valid,
    input  logic [rv_pkg::xlen-1:0]      inst,
    output logic [rv_pkg::xlen-1:0]      pc,
    output logic                         retire_valid,
    output logic [rv_pkg::xlen-1:0]      retire_pc,
    output logic [rv_pkg::reg_idx_w-1:0] retire_rd,
    output logic                         retire_we,
    output logic [rv_pkg::xlen-1:0]      retire_wdata,
    output logic [rv_pkg::xlen-1:0]      retire_next_pc,
    output logic                         retire_illegal
);
    import rv_pkg::*;

    // decode
    logic [reg_idx_w-1:0] rd, rs1, rs2;
    logic [xlen-1:0]      imm;
    inst_fmt_t            fmt;
    opcode_t              opcode;
    logic [2:0]           funct3;
    alu_op_t              alu_op;
    wb_sel_t              wb_sel;
    logic                 illegal;

    // operands and results
    logic [xlen-1:0]      rdata1, rdata2;
    logic [xlen-1:0]      alu_result;
    logic                 taken;
    logic [xlen-1:0]      target;

    // write-back port
    logic                 wen;
    logic [reg_idx_w-1:0] waddr;
    logic [xlen-1:0]      wdata;

    instr_decoder u_decoder (
        .inst(inst), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .fmt(fmt),
        .opcode(opcode), .funct3(funct3), .alu_op(alu_op), .wb_sel(wb_sel),
        .illegal(illegal)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .raddr1(rs1), .raddr2(rs2),
        .rdata1(rdata1), .rdata2(rdata2), .wen(wen), .waddr(waddr), .wdata(wdata)
    );

    // alu and branch unit see the same operands
    int_alu u_alu (
        .fmt(fmt), .opcode(opcode), .alu_op(alu_op), .rdata1(rdata1),
        .rdata2(rdata2), .imm(imm), .pc(pc), .alu_result(alu_result)
    );

    branch_unit u_branch (
        .fmt(fmt), .opcode(opcode), .funct3(funct3), .rdata1(rdata1),
        .rdata2(rdata2), .imm(imm), .pc(pc), .taken(taken), .target(target)
    );

    retire_unit #(
        .reset_pc(reset_pc)
    ) u_retire (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .rd(rd),
        .wb_sel(wb_sel), .illegal(illegal), .alu_result(alu_result),
        .taken(taken), .target(target), .pc(pc),
        .wen(wen), .waddr(waddr), .wdata(wdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_wdata(retire_wdata),
        .retire_next_pc(retire_next_pc), .retire_illegal(retire_illegal)
    );

endmodule

//--- src/rv_pkg.sv
/* RV32I core shared types */
package rv_pkg;

    localparam int xlen = 32;      // data and address width
    localparam int reg_idx_w = 5;  // 32 architectural registers

    // major opcodes the core executes, anything else is illegal
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011
    } opcode_t;

    // instruction formats, fmt_n for unknown opcodes
    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_u,
        fmt_j,
        fmt_b,
        fmt_n
    } inst_fmt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // funct3 encodings of the branch instructions
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_cond_t;

    // write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_link,  // pc + 4 for jal / jalr
        wb_none
    } wb_sel_t;

endpackage

//--- tests/rv_core_tb.sv
/* rv_core random testbench */
module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam logic [xlen-1:0] boot_pc = 32'h8000_0000;
    localparam int n_alu = 400;
    localparam int n_br = 300;
    localparam int n_jump = 100;
    localparam int n_ill = 60;
    localparam int n_idle = 40;
    // each instruction may carry one idle cycle and branches need two preloads
    localparam int max_cycles =
        4 + 2 * (n_alu + 3 * n_br + n_jump + n_ill + n_idle + 8 + 6) + 100;

    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        logic [reg_idx_w-1:0] rd;
        logic                 we;
        logic [xlen-1:0]      wdata;
        logic [xlen-1:0]      next_pc;
        logic                 illegal;
    } retire_rec_t;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 inst_valid;
    logic [xlen-1:0]      inst;
    logic [xlen-1:0]      pc;
    logic                 retire_valid;
    logic [xlen-1:0]      retire_pc;
    logic [reg_idx_w-1:0] retire_rd;
    logic                 retire_we;
    logic [xlen-1:0]      retire_wdata;
    logic [xlen-1:0]      retire_next_pc;
    logic                 retire_illegal;

    logic [31:0]     rng_state = 32'hc8f4_f877;
    logic [xlen-1:0] model_regs [32];
    logic [xlen-1:0] model_pc;
    retire_rec_t     exp_q [$];
    int              errors = 0;
    int              checks = 0;
    int              n_steps = 0;
    int              cycles = 0;
    int              err_mark;
    int              step_mark;
    string           cur_test;

    rv_core dut_i (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst), .pc(pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_wdata(retire_wdata),
        .retire_next_pc(retire_next_pc), .retire_illegal(retire_illegal)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run exceeded %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // LCG with halves swapped so the low bits are usable
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};
    endfunction

    function automatic logic [reg_idx_w-1:0] rand_reg();
        logic [31:0] r;
        r = next_rand();
        return (r[31:29] == 3'b000) ? r[4:0] : {2'b00, r[2:0]};  // mostly x0..x7
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // reference ALU where alt selects sub / sra
    function automatic logic [xlen-1:0] alu_ref(logic [2:0] f3, logic alt,
                                                 logic [xlen-1:0] x, logic [xlen-1:0] y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3:    return (x < y) ? 32'd1 : 32'd0;
            3'd4:    return x ^ y;
            3'd5: begin
                if (alt) begin
                    return $signed(x) >>> y[4:0];  // sign fill
                end else begin
                    return x >> y[4:0];
                end
            end
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_holds(logic [2:0] f3, logic [xlen-1:0] x,
                                          logic [xlen-1:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // ISA model that executes one word and returns what the core should retire
    function automatic retire_rec_t model_exec(logic [31:0] ins);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [4:0]      rd;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm_i;
        logic [xlen-1:0] imm_b;
        logic [xlen-1:0] imm_u;
        logic [xlen-1:0] imm_j;
        logic [xlen-1:0] seq;
        retire_rec_t     rec;
        opc   = ins[6:0];
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        seq   = model_pc + 32'd4;
        rec   = '{valid: 1'b1, pc: model_pc, rd: rd, we: 1'b0, wdata: '0,
                  next_pc: seq, illegal: 1'b0};
        case (opc)
            op: begin
                rec.we    = 1'b1;
                rec.wdata = alu_ref(f3, ins[30], a, b);
            end
            op_imm: begin
                rec.we    = 1'b1;
                rec.wdata = alu_ref(f3, (f3 == 3'b101) && ins[30], a, imm_i);  // no subi
            end
            lui: begin
                rec.we    = 1'b1;
                rec.wdata = imm_u;
            end
            auipc: begin
                rec.we    = 1'b1;
                rec.wdata = model_pc + imm_u;
            end
            jal: begin
                rec.we      = 1'b1;
                rec.wdata   = seq;
                rec.next_pc = model_pc + imm_j;
            end
            jalr: begin
                rec.we      = 1'b1;
                rec.wdata   = seq;
                rec.next_pc = (a + imm_i) & ~32'h1;
            end
            branch: begin
                if (branch_holds(f3, a, b)) begin
                    rec.next_pc = model_pc + imm_b;
                end
            end
            default: rec.illegal = 1'b1;
        endcase
        if (rec.we && rd != 5'd0) begin
            model_regs[rd] = rec.wdata;
        end
        model_pc = rec.next_pc;
        return rec;
    endfunction

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input logic [reg_idx_w-1:0] got,
                             input logic [reg_idx_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_record(input retire_rec_t rec);
        check_bit("retire_valid", retire_valid, rec.valid);
        check_bit("retire_we", retire_we, rec.we);
        check_word("pc", pc, rec.next_pc);  // idle cycles expect the pc held
        if (rec.valid) begin
            check_word("retire_pc", retire_pc, rec.pc);
            check_idx("retire_rd", retire_rd, rec.rd);
            check_word("retire_next_pc", retire_next_pc, rec.next_pc);
            check_bit("retire_illegal", retire_illegal, rec.illegal);
            if (rec.we) begin
                check_word("retire_wdata", retire_wdata, rec.wdata);
            end
        end
    endtask

    // one falling edge checks last cycle's retire and drives the next input
    task automatic drive_cycle(input logic valid, input logic [xlen-1:0] word);
        retire_rec_t rec;
        @(negedge clk);
        if (exp_q.size() > 0) begin
            check_record(exp_q.pop_front());
        end
        inst_valid = valid;
        inst       = word;
        if (valid) begin
            rec = model_exec(word);
            n_steps++;
        end else begin
            rec = '{valid: 1'b0, pc: model_pc, rd: '0, we: 1'b0, wdata: '0,
                    next_pc: model_pc, illegal: 1'b0};
        end
        exp_q.push_back(rec);
    endtask

    task automatic issue(input logic [xlen-1:0] word);
        if (next_rand() % 32'd8 == 32'd0) begin
            drive_cycle(1'b0, next_rand());  // random bubble
        end
        drive_cycle(1'b1, word);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_mark  = errors;
        step_mark = n_steps;
    endtask

    task automatic end_test();
        drive_cycle(1'b0, '0);  // flushes the last check
        $display("%-10s %0d instructions, %0d errors", cur_test, n_steps - step_mark,
                 errors - err_mark);
    endtask

    function automatic logic [31:0] gen_alu();
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r  = next_rand();
        r2 = next_rand();
        f3 = r[14:12];
        case (r[1:0])
            2'd0: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[20]) ? 7'b0100000 : 7'b0000000;
                return r_type(f7, rand_reg(), rand_reg(), f3, rand_reg(), op);
            end
            2'd1: begin
                imm = r2[11:0];
                if (f3 == 3'd1) begin
                    imm = {7'b0, r2[4:0]};
                end else if (f3 == 3'd5) begin
                    imm = {1'b0, r[20], 5'b0, r2[4:0]};  // srli / srai
                end
                return i_type(imm, rand_reg(), f3, rand_reg(), op_imm);
            end
            2'd2:    return u_type(r2[19:0], rand_reg(), lui);
            default: return u_type(r2[19:0], rand_reg(), auipc);
        endcase
    endfunction

    // small values so equal operands come up often
    function automatic logic [11:0] small_val();
        logic [31:0] v;
        v = next_rand();
        return (v[30:28] == 3'b000) ? v[11:0] : {{9{v[2]}}, v[2:0]};
    endfunction

    function automatic logic [2:0] branch_f3(logic [31:0] r);
        case (r % 32'd6)
            32'd0:   return 3'b000;
            32'd1:   return 3'b001;
            32'd2:   return 3'b100;
            32'd3:   return 3'b101;
            32'd4:   return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic is_known(logic [6:0] opc);
        return opc == op || opc == op_imm || opc == lui || opc == auipc ||
               opc == jal || opc == jalr || opc == branch;
    endfunction

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  opc;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        model_pc   = boot_pc;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test("reset");
        check_word("pc", pc, boot_pc);
        check_bit("retire_valid", retire_valid, 1'b0);
        check_bit("retire_we", retire_we, 1'b0);
        end_test();

        begin_test("alu");
        for (int i = 0; i < n_alu; i++) begin
            issue(gen_alu());
        end
        end_test();

        begin_test("branch");
        for (int i = 0; i < n_br; i++) begin
            r   = next_rand();
            r2  = next_rand();
            rs1 = {2'b00, r[2:0]};
            rs2 = {2'b00, r[5:3]};
            issue(i_type(small_val(), 5'd0, 3'b000, rs1, op_imm));
            issue(i_type(small_val(), 5'd0, 3'b000, rs2, op_imm));
            issue(b_type({r2[12:1], 1'b0}, rs2, rs1, branch_f3(r)));
        end
        end_test();

        begin_test("jump");
        for (int i = 0; i < n_jump; i++) begin
            r  = next_rand();
            r2 = next_rand();
            if (r[0]) begin
                issue(j_type({r2[20:1], 1'b0}, rand_reg()));
            end else begin
                issue(i_type(r2[11:0], rand_reg(), 3'b000, rand_reg(), jalr));
            end
        end
        end_test();

        begin_test("illegal");
        for (int i = 0; i < n_ill; i++) begin
            r = next_rand();
            case (r[2:0])
                3'd0:    opc = 7'b0000011;  // load
                3'd1:    opc = 7'b0100011;  // store
                3'd2:    opc = 7'b1110011;  // system
                3'd3:    opc = 7'b0001111;  // fence
                default: begin
                    opc = r[31:25];
                    while (is_known(opc)) begin
                        opc = opc + 7'd1;
                    end
                end
            endcase
            issue({r[31:7], opc});
        end
        end_test();

        begin_test("idle");
        for (int i = 0; i < n_idle; i++) begin
            drive_cycle(1'b0, next_rand());
        end
        // read back x0..x7 through or x0, xk, x0
        for (int k = 0; k < 8; k++) begin
            drive_cycle(1'b1, r_type(7'b0, 5'd0, 5'(k), 3'b110, 5'd0, op));
        end
        end_test();

        @(negedge clk);
        while (exp_q.size() > 0) begin
            check_record(exp_q.pop_front());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
